//--- include/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// ============================================================
// datapath and register file
// ============================================================
`define CORE_XLEN       32
`define CORE_RESET_PC   32'h8000_0000
`define CORE_REG_COUNT  16
`define CORE_REG_AW     4

// ============================================================
// machine CSRs
// ============================================================
`define CSR_MCYCLE      12'hB00
`define CSR_MCYCLEH     12'hB80
`define CSR_MVENDORID   12'hF11
`define CSR_MARCHID     12'hF12

// read-only ID words
`define CORE_MVENDORID  32'h7973_7978
`define CORE_MARCHID    32'h017E_B18A

`endif

//--- src/core_pkg.sv
`include "core_config.svh"

package core_pkg;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,
    OP_IMM    = 7'b0010011,
    OP_STORE  = 7'b0100011,
    OP_REG    = 7'b0110011,
    OP_LUI    = 7'b0110111,
    OP_JALR   = 7'b1100111,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  // ============================================================
  // instruction word views
  // ============================================================
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_e    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    opcode_e     opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    u_fmt_t u_fmt;
  } inst_u;

  // ============================================================
  // stage records
  // ============================================================
  typedef struct packed {
    logic                    alu_reg;
    logic                    alu_imm;
    logic                    lui;
    logic                    jalr;
    logic                    load;
    logic                    store;
    logic                    csr_rw;
    logic                    csr_rs;
    logic                    byte_op;
    logic [`CORE_REG_AW-1:0] rd;
    logic [`CORE_REG_AW-1:0] rs1;
    logic [`CORE_REG_AW-1:0] rs2;
    logic [11:0]             csr_addr;
    logic [`CORE_XLEN-1:0]   imm;
    logic                    rd_write;
  } decoded_t;

  typedef struct packed {
    logic                  valid;
    logic [`CORE_XLEN-1:0] addr;
  } imem_req_t;

  typedef struct packed {
    logic                  valid;
    logic [`CORE_XLEN-1:0] data;
  } imem_resp_t;

  typedef struct packed {
    logic                  valid;
    logic [`CORE_XLEN-1:0] addr;
    logic                  wen;
    logic [`CORE_XLEN-1:0] wdata;
    logic [3:0]            wmask;
    logic [1:0]            size;
  } dmem_req_t;

  typedef struct packed {
    logic                  valid;
    logic [`CORE_XLEN-1:0] rdata;
  } dmem_resp_t;

  // one retired instruction
  typedef struct packed {
    logic                    valid;
    logic                    rd_write;
    logic [`CORE_REG_AW-1:0] rd;
    logic [`CORE_XLEN-1:0]   wdata;
    logic [`CORE_XLEN-1:0]   next_pc;
    logic                    csr_write;
    logic                    csr_set;
  } commit_t;

endpackage

//--- src/fetch_stage.sv
`include "core_config.svh"

module fetch_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  core_pkg::commit_t     commit,
  input  core_pkg::imem_resp_t  imem_resp,
  output core_pkg::imem_req_t   imem_req,
  output core_pkg::inst_u       inst,
  output logic                  inst_valid,
  output logic [`CORE_XLEN-1:0] pc
);

  localparam logic ST_IDLE = 1'b0;
  localparam logic ST_WAIT = 1'b1;

  logic                  state;
  logic                  boot;
  logic [`CORE_XLEN-1:0] fetch_pc;

  // first fetch comes from the reset PC, later ones from commit
  assign fetch_pc = boot ? pc : commit.next_pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= ST_IDLE;
      boot           <= 1'b1;
      pc             <= `CORE_RESET_PC;
      imem_req.valid <= 1'b0;
      inst_valid     <= 1'b0;
    end else begin
      // both strobes are single-cycle pulses
      imem_req.valid <= 1'b0;
      inst_valid     <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (boot || commit.valid) begin
            boot           <= 1'b0;
            pc             <= fetch_pc;
            imem_req.valid <= 1'b1;
            imem_req.addr  <= fetch_pc;
            state          <= ST_WAIT;
          end
        end
        default: begin
          if (imem_resp.valid) begin
            inst       <= imem_resp.data;
            inst_valid <= 1'b1;
            state      <= ST_IDLE;
          end
        end
      endcase
    end
  end

endmodule

//--- src/decode_stage.sv
`include "core_config.svh"

module decode_stage (
  input  core_pkg::inst_u    inst,
  output core_pkg::decoded_t dec
);

  logic [`CORE_XLEN-1:0] imm_i;
  logic [`CORE_XLEN-1:0] imm_s;
  logic [`CORE_XLEN-1:0] imm_u;
  logic [2:0]            funct3;

  assign funct3 = inst.r_fmt.funct3;
  assign imm_i  = {{(`CORE_XLEN-12){inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
  assign imm_s  = {{(`CORE_XLEN-12){inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi,
                   inst.s_fmt.imm_lo};
  assign imm_u  = {inst.u_fmt.imm, 12'b0};

  always_comb begin
    dec          = '0;
    // only the low index bits reach the 16-entry file
    dec.rd       = inst.r_fmt.rd[`CORE_REG_AW-1:0];
    dec.rs1      = inst.r_fmt.rs1[`CORE_REG_AW-1:0];
    dec.rs2      = inst.r_fmt.rs2[`CORE_REG_AW-1:0];
    dec.csr_addr = inst.i_fmt.imm;
    case (inst.r_fmt.opcode)
      core_pkg::OP_REG:   dec.alu_reg = (funct3 == 3'b000) && (inst.r_fmt.funct7 == 7'b0);
      core_pkg::OP_IMM:   dec.alu_imm = (funct3 == 3'b000);
      core_pkg::OP_LUI:   dec.lui     = 1'b1;
      core_pkg::OP_JALR:  dec.jalr    = (funct3 == 3'b000);
      core_pkg::OP_LOAD: begin
        // lw or lbu
        dec.load    = (funct3 == 3'b010) || (funct3 == 3'b100);
        dec.byte_op = (funct3 == 3'b100);
      end
      core_pkg::OP_STORE: begin
        // sw or sb
        dec.store   = (funct3 == 3'b010) || (funct3 == 3'b000);
        dec.byte_op = (funct3 == 3'b000);
      end
      core_pkg::OP_SYSTEM: begin
        dec.csr_rw = (funct3 == 3'b001);
        dec.csr_rs = (funct3 == 3'b010);
      end
      default: ;
    endcase

    // anything else retires as a no-op
    dec.rd_write = dec.alu_reg | dec.alu_imm | dec.lui | dec.jalr | dec.load |
                   dec.csr_rw | dec.csr_rs;

    if (dec.alu_imm || dec.load || dec.jalr) begin
      dec.imm = imm_i;
    end else if (dec.store) begin
      dec.imm = imm_s;
    end else if (dec.lui) begin
      dec.imm = imm_u;
    end
  end

endmodule

//--- src/reg_file.sv
`include "core_config.svh"

module reg_file (
  input  logic                    clk,
  input  logic [`CORE_REG_AW-1:0] rs1,
  input  logic [`CORE_REG_AW-1:0] rs2,
  input  core_pkg::commit_t       commit,
  output logic [`CORE_XLEN-1:0]   rs1_data,
  output logic [`CORE_XLEN-1:0]   rs2_data
);

  logic [`CORE_XLEN-1:0] regs [`CORE_REG_COUNT];

  // write port driven by the retire record
  always_ff @(posedge clk) begin
    if (commit.valid && commit.rd_write) begin
      regs[commit.rd] <= commit.wdata;
    end
  end

  // x0 is hardwired to zero on read
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- src/execute_stage.sv
`include "core_config.svh"

module execute_stage (
  input  core_pkg::decoded_t    dec,
  input  logic [`CORE_XLEN-1:0] rs1_data,
  input  logic [`CORE_XLEN-1:0] rs2_data,
  output logic [`CORE_XLEN-1:0] alu_out
);

  logic [`CORE_XLEN-1:0] op_a;
  logic [`CORE_XLEN-1:0] op_b;

  // lui adds its upper immediate to zero
  assign op_a = dec.lui ? '0 : rs1_data;

  // register form for add, immediate for everything else
  assign op_b = dec.alu_reg ? rs2_data : dec.imm;

  // also the effective address of loads, stores and jalr
  assign alu_out = op_a + op_b;

endmodule

//--- src/csr_file.sv
`include "core_config.svh"

module csr_file (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [11:0]           csr_addr,
  input  core_pkg::commit_t     commit,
  input  logic [`CORE_XLEN-1:0] csr_src,
  output logic [`CORE_XLEN-1:0] csr_rdata
);

  logic [63:0]           mcycle;
  logic [`CORE_XLEN-1:0] cur_half;
  logic [`CORE_XLEN-1:0] new_half;
  logic                  wr_en;
  logic                  wr_lo;
  logic                  wr_hi;

  // ============================================================
  // write rules
  // ============================================================
  assign cur_half = (csr_addr == `CSR_MCYCLEH) ? mcycle[63:32] : mcycle[31:0];
  assign new_half = commit.csr_write ? csr_src : (cur_half | csr_src);

  // csrrs with a zero source leaves the counter alone
  assign wr_en = commit.valid &&
                 (commit.csr_write || (commit.csr_set && (csr_src != '0)));
  assign wr_lo = wr_en && (csr_addr == `CSR_MCYCLE);
  assign wr_hi = wr_en && (csr_addr == `CSR_MCYCLEH);

  always_ff @(posedge clk) begin
    if (rst) begin
      mcycle <= '0;
    end else begin
      mcycle <= mcycle + 64'd1;
      // a written half takes the new value instead of the increment
      if (wr_lo) begin
        mcycle[31:0] <= new_half;
      end
      if (wr_hi) begin
        mcycle[63:32] <= new_half;
      end
    end
  end

  // ============================================================
  // read mux
  // ============================================================
  always_comb begin
    case (csr_addr)
      `CSR_MCYCLE:    csr_rdata = mcycle[31:0];
      `CSR_MCYCLEH:   csr_rdata = mcycle[63:32];
      `CSR_MVENDORID: csr_rdata = `CORE_MVENDORID;
      `CSR_MARCHID:   csr_rdata = `CORE_MARCHID;
      default:        csr_rdata = '0;
    endcase
  end

endmodule

//--- src/mem_stage.sv
`include "core_config.svh"

module mem_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inst_valid,
  input  core_pkg::decoded_t    dec,
  input  logic [`CORE_XLEN-1:0] alu_out,
  input  logic [`CORE_XLEN-1:0] rs2_data,
  input  core_pkg::dmem_resp_t  dmem_resp,
  output core_pkg::dmem_req_t   dmem_req,
  output logic [`CORE_XLEN-1:0] load_data,
  output logic                  mem_done
);

  localparam logic ST_IDLE = 1'b0;
  localparam logic ST_WAIT = 1'b1;

  logic                  state;
  logic [1:0]            byte_off;
  logic [`CORE_XLEN-1:0] rdata_shift;

  assign byte_off = alu_out[1:0];

  // bring the addressed lane down to bit 0
  assign rdata_shift = dmem_resp.rdata >> {dmem_req.addr[1:0], 3'b000};

  // ============================================================
  // request / response FSM
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= ST_IDLE;
      dmem_req.valid <= 1'b0;
      mem_done       <= 1'b0;
    end else begin
      dmem_req.valid <= 1'b0;
      mem_done       <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (inst_valid && (dec.load || dec.store)) begin
            dmem_req.valid <= 1'b1;
            dmem_req.addr  <= alu_out;
            dmem_req.wen   <= dec.store;
            // byte or word lanes at the address offset
            dmem_req.wmask <= (dec.byte_op ? 4'b0001 : 4'b1111) << byte_off;
            dmem_req.wdata <= rs2_data << {byte_off, 3'b000};
            dmem_req.size  <= dec.byte_op ? 2'd0 : 2'd2;
            state          <= ST_WAIT;
          end
        end
        default: begin
          // request fields stay put until the response
          if (dmem_resp.valid) begin
            if (dec.byte_op) begin
              // lbu zero-extends
              load_data <= {{(`CORE_XLEN-8){1'b0}}, rdata_shift[7:0]};
            end else begin
              load_data <= rdata_shift;
            end
            mem_done <= 1'b1;
            state    <= ST_IDLE;
          end
        end
      endcase
    end
  end

endmodule

//--- src/writeback_stage.sv
`include "core_config.svh"

module writeback_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inst_valid,
  input  core_pkg::decoded_t    dec,
  input  logic [`CORE_XLEN-1:0] pc,
  input  logic [`CORE_XLEN-1:0] alu_out,
  input  logic [`CORE_XLEN-1:0] csr_rdata,
  input  logic [`CORE_XLEN-1:0] rs1_data,
  input  logic [`CORE_XLEN-1:0] load_data,
  input  logic                  mem_done,
  output core_pkg::commit_t     commit,
  output logic [`CORE_XLEN-1:0] csr_src
);

  localparam logic ST_IDLE = 1'b0;
  localparam logic ST_MEM  = 1'b1;

  logic                  state;
  logic                  mem_op;
  logic                  fire;
  logic [`CORE_XLEN-1:0] pc_plus4;
  logic [`CORE_XLEN-1:0] wb_data;
  logic [`CORE_XLEN-1:0] next_pc;

  assign mem_op   = dec.load | dec.store;
  assign pc_plus4 = pc + `CORE_XLEN'd4;

  // memory ops wait for mem_done, the rest retire right away
  assign fire = ((state == ST_IDLE) && inst_valid && !mem_op) ||
                ((state == ST_MEM) && mem_done);

  assign wb_data = dec.jalr                  ? pc_plus4  :
                   (dec.csr_rw | dec.csr_rs) ? csr_rdata :
                   dec.load                  ? load_data : alu_out;
  assign next_pc = dec.jalr ? {alu_out[`CORE_XLEN-1:1], 1'b0} : pc_plus4;

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= ST_IDLE;
      commit.valid <= 1'b0;
    end else begin
      commit.valid <= fire;
      if (state == ST_IDLE && inst_valid && mem_op) begin
        state <= ST_MEM;
      end else if (state == ST_MEM && mem_done) begin
        state <= ST_IDLE;
      end
      if (fire) begin
        commit.rd_write  <= dec.rd_write;
        commit.rd        <= dec.rd;
        commit.wdata     <= wb_data;
        commit.next_pc   <= next_pc;
        commit.csr_write <= dec.csr_rw;
        commit.csr_set   <= dec.csr_rs;
        csr_src          <= rs1_data;
      end
    end
  end

endmodule

//--- src/core_top.sv
`include "core_config.svh"

module core_top (
  input  logic                 clk,
  input  logic                 rst,
  input  core_pkg::imem_resp_t imem_resp,
  input  core_pkg::dmem_resp_t dmem_resp,
  output core_pkg::imem_req_t  imem_req,
  output core_pkg::dmem_req_t  dmem_req
);

  core_pkg::inst_u       inst;
  core_pkg::decoded_t    dec;
  core_pkg::commit_t     commit;
  logic                  inst_valid;
  logic                  mem_done;
  logic [`CORE_XLEN-1:0] pc;
  logic [`CORE_XLEN-1:0] rs1_data;
  logic [`CORE_XLEN-1:0] rs2_data;
  logic [`CORE_XLEN-1:0] alu_out;
  logic [`CORE_XLEN-1:0] csr_rdata;
  logic [`CORE_XLEN-1:0] csr_src;
  logic [`CORE_XLEN-1:0] load_data;

  // ============================================================
  // stage chain
  // ============================================================
  fetch_stage i_fetch (
    .clk(clk), .rst(rst), .commit(commit), .imem_resp(imem_resp),
    .imem_req(imem_req), .inst(inst), .inst_valid(inst_valid), .pc(pc)
  );

  decode_stage i_decode (.inst(inst), .dec(dec));

  reg_file i_regs (
    .clk(clk), .rs1(dec.rs1), .rs2(dec.rs2), .commit(commit),
    .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  execute_stage i_exec (
    .dec(dec), .rs1_data(rs1_data), .rs2_data(rs2_data), .alu_out(alu_out)
  );

  csr_file i_csr (
    .clk(clk), .rst(rst), .csr_addr(dec.csr_addr), .commit(commit),
    .csr_src(csr_src), .csr_rdata(csr_rdata)
  );

  mem_stage i_mem (
    .clk(clk), .rst(rst), .inst_valid(inst_valid), .dec(dec), .alu_out(alu_out),
    .rs2_data(rs2_data), .dmem_resp(dmem_resp), .dmem_req(dmem_req),
    .load_data(load_data), .mem_done(mem_done)
  );

  // retire record feeds fetch, registers and CSRs
  writeback_stage i_wb (
    .clk(clk), .rst(rst), .inst_valid(inst_valid), .dec(dec), .pc(pc),
    .alu_out(alu_out), .csr_rdata(csr_rdata), .rs1_data(rs1_data),
    .load_data(load_data), .mem_done(mem_done), .commit(commit), .csr_src(csr_src)
  );

endmodule

//--- bench/check_monitor.sv
`include "core_config.svh"

module check_monitor #(
  parameter int PROG_WORDS = 96
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [31:0]          prog [PROG_WORDS],
  input  core_pkg::dmem_req_t  dmem_req,
  input  core_pkg::dmem_resp_t dmem_resp,
  output logic                 done,
  output int                   error_count,
  output int                   tests_passed,
  output int                   tests_failed
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int STORE_TIMEOUT = 500;
  localparam int QUIET_CYCLES  = 100;

  typedef struct packed {
    logic [31:0] addr;
    logic [3:0]  wmask;
    logic [31:0] wdata;
    logic [1:0]  size;
    logic        cyc;
  } store_t;

  store_t      expected [$];
  logic [31:0] ref_mem [logic [31:0]];
  string       group_name [6];
  int          cur_group;
  logic        group_bad;
  logic        have_cycle;
  logic [31:0] last_cycle;
  int          resp_count;
  int          expected_accesses;

  // ============================================================
  // ISA-level reference of the program
  // ============================================================
  function automatic void run_reference();
    logic [31:0] regs [16];
    logic [15:0] tag;
    logic [31:0] pc;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] res;
    logic [31:0] old;
    logic [31:0] src;
    logic [31:0] word;
    logic [31:0] next;
    logic [31:0] mcycleh;
    logic [3:0]  rd;
    logic [3:0]  rs1;
    logic [3:0]  rs2;
    logic [3:0]  mask;
    logic [2:0]  f3;
    logic        wr;
    logic        cyc;
    logic        stop;
    int          idx;
    store_t      st;
    for (int i = 0; i < 16; i++) begin
      regs[i] = '0;
    end
    tag = '0;
    pc = `CORE_RESET_PC;
    mcycleh = '0;
    stop = 1'b0;
    expected_accesses = 0;
    for (int step = 0; step < 1000 && !stop; step++) begin
      idx = int'((pc - `CORE_RESET_PC) >> 2);
      w = (idx >= 0 && idx < PROG_WORDS) ? prog[idx] : 32'h0000_0013;
      rd = w[10:7];
      rs1 = w[18:15];
      rs2 = w[23:20];
      f3 = w[14:12];
      next = pc + 32'd4;
      wr = 1'b0;
      cyc = 1'b0;
      res = '0;
      case (w[6:0])
        7'h13: begin
          wr = (f3 == 3'd0);
          res = regs[rs1] + {{20{w[31]}}, w[31:20]};
        end
        7'h33: begin
          wr = (f3 == 3'd0) && (w[31:25] == 7'd0);
          res = regs[rs1] + regs[rs2];
        end
        7'h37: begin
          wr = 1'b1;
          res = {w[31:12], 12'h000};
        end
        7'h67: if (f3 == 3'd0) begin
          a = regs[rs1] + {{20{w[31]}}, w[31:20]};
          wr = 1'b1;
          res = pc + 32'd4;
          next = {a[31:1], 1'b0};
          stop = (next == pc);
        end
        7'h03: begin
          a = regs[rs1] + {{20{w[31]}}, w[31:20]};
          word = ref_mem.exists({a[31:2], 2'b00}) ? ref_mem[{a[31:2], 2'b00}] : '0;
          wr = (f3 == 3'd2) || (f3 == 3'd4);
          res = (f3 == 3'd2) ? word : ((word >> {a[1:0], 3'b000}) & 32'hFF);
          if (wr) expected_accesses++;
        end
        7'h23: if (f3 == 3'd0 || f3 == 3'd2) begin
          a = regs[rs1] + {{20{w[31]}}, w[31:25], w[11:7]};
          mask = ((f3 == 3'd0) ? 4'b0001 : 4'b1111) << a[1:0];
          st.addr = a;
          st.wmask = mask;
          st.wdata = regs[rs2] << {a[1:0], 3'b000};
          st.size = (f3 == 3'd0) ? 2'd0 : 2'd2;
          st.cyc = tag[rs2];
          expected.push_back(st);
          expected_accesses++;
          word = ref_mem.exists({a[31:2], 2'b00}) ? ref_mem[{a[31:2], 2'b00}] : '0;
          for (int b = 0; b < 4; b++) begin
            if (mask[b]) word[8*b +: 8] = st.wdata[8*b +: 8];
          end
          ref_mem[{a[31:2], 2'b00}] = word;
        end
        7'h73: if (f3 == 3'd1 || f3 == 3'd2) begin
          src = regs[rs1];
          case (w[31:20])
            12'hB00: cyc = 1'b1;
            12'hB80: old = mcycleh;
            12'hF11: old = 32'h7973_7978;
            12'hF12: old = 32'h017E_B18A;
            default: old = '0;
          endcase
          if (cyc) old = '0;
          if (w[31:20] == 12'hB80) begin
            if (f3 == 3'd1) mcycleh = src;
            else if (src != '0) mcycleh = old | src;
          end
          wr = 1'b1;
          res = old;
        end
        default: ;
      endcase
      if (wr && rd != 4'd0) begin
        regs[rd] = res;
        tag[rd] = cyc;
      end
      pc = next;
    end
  endfunction

  task automatic finish_group();
    if (cur_group >= 0) begin
      $display("test %s: %s", group_name[cur_group], group_bad ? "fail" : "pass");
      if (group_bad) tests_failed++;
      else tests_passed++;
    end
  endtask

  task automatic check_store(input store_t e);
    int   g;
    logic ok;
    g = int'(e.addr[10:8]);
    if (g > 5) g = 5;
    if (g != cur_group) begin
      finish_group();
      cur_group = g;
      group_bad = 1'b0;
    end
    ok = (dmem_req.addr == e.addr) && (dmem_req.wmask == e.wmask) &&
         (dmem_req.size == e.size);
    if (e.cyc) begin
      // counter samples only need to rise
      ok = ok && (!have_cycle || dmem_req.wdata > last_cycle);
      have_cycle = 1'b1;
      last_cycle = dmem_req.wdata;
    end else begin
      ok = ok && (dmem_req.wdata == e.wdata);
    end
    if (!ok) begin
      $display("MISMATCH %0t: store addr %h mask %b size %0d data %h, expected %h %b %0d %h",
               $time, dmem_req.addr, dmem_req.wmask, dmem_req.size, dmem_req.wdata,
               e.addr, e.wmask, e.size, e.wdata);
      error_count++;
      group_bad = 1'b1;
    end
  endtask

  always @(negedge clk) begin
    if (dmem_resp.valid) resp_count++;
  end

  // ============================================================
  // compare process
  // ============================================================
  initial begin
    int idle;
    int waited;
    done = 1'b0;
    error_count = 0;
    tests_passed = 0;
    tests_failed = 0;
    resp_count = 0;
    cur_group = -1;
    group_bad = 1'b0;
    have_cycle = 1'b0;
    last_cycle = '0;
    group_name = '{"arithmetic", "byte stores", "loads", "jumps", "csrs", "x0"};
    waited = 0;
    @(negedge clk);
    while (rst && waited < 100) begin
      @(negedge clk);
      waited++;
    end
    if (rst) begin
      $display("reset never released");
      error_count++;
    end
    run_reference();
    idle = 0;
    while (expected.size() > 0 && idle < STORE_TIMEOUT) begin
      @(negedge clk);
      idle++;
      if (dmem_req.valid && dmem_req.wen) begin
        idle = 0;
        check_store(expected.pop_front());
      end
    end
    if (expected.size() > 0) begin
      $display("timeout: %0d expected stores never arrived", expected.size());
      error_count++;
      group_bad = 1'b1;
    end
    finish_group();
    // program now spins on its final jalr
    for (int i = 0; i < QUIET_CYCLES; i++) begin
      @(negedge clk);
      if (dmem_req.valid && dmem_req.wen) begin
        $display("unexpected store to %h after the last expected one", dmem_req.addr);
        error_count++;
      end
    end
    // every load and store gets exactly one data bus response
    if (resp_count != expected_accesses) begin
      $display("data bus answered %0d accesses, but the program makes %0d", resp_count,
               expected_accesses);
      error_count++;
    end
    done = 1'b1;
  end

endmodule

//--- bench/tb_top.sv
`include "core_config.svh"

module tb_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PROG_WORDS  = 96;
  localparam int RUN_TIMEOUT = 20000;

  logic                 clk;
  logic                 rst;
  core_pkg::imem_req_t  imem_req;
  core_pkg::imem_resp_t imem_resp;
  core_pkg::dmem_req_t  dmem_req;
  core_pkg::dmem_resp_t dmem_resp;
  logic [31:0]          prog [PROG_WORDS];
  int                   prog_len;
  logic [31:0]          dmem [logic [31:0]];
  logic                 mon_done;
  int                   error_count;
  int                   tests_passed;
  int                   tests_failed;
  logic                 ipend;
  logic [31:0]          iaddr;
  int                   icnt;
  logic                 dpend;
  core_pkg::dmem_req_t  dreq;
  int                   dcnt;
  logic [31:0]          dword;
  logic [31:0]          ioff;

  core_top i_dut (
    .clk(clk), .rst(rst), .imem_resp(imem_resp), .dmem_resp(dmem_resp),
    .imem_req(imem_req), .dmem_req(dmem_req)
  );

  check_monitor #(.PROG_WORDS(PROG_WORDS)) i_check (
    .clk(clk), .rst(rst), .prog(prog), .dmem_req(dmem_req), .dmem_resp(dmem_resp),
    .done(mon_done), .error_count(error_count), .tests_passed(tests_passed),
    .tests_failed(tests_failed)
  );

  function automatic logic [31:0] itype_word(logic [11:0] imm, logic [4:0] rs1,
                                             logic [2:0] f3, logic [4:0] rd,
                                             logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] stype_word(logic [11:0] imm, logic [4:0] rs2,
                                             logic [4:0] rs1, logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] add_word(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
    return {7'h00, rs2, rs1, 3'b000, rd, 7'h33};
  endfunction

  function automatic logic [31:0] lui_word(logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, 7'h37};
  endfunction

  // unwritten data words read back a pattern of their address
  function automatic logic [31:0] fill_word(logic [31:0] addr);
    return {addr[7:0], addr[31:8]} ^ 32'h5A5A_A5A5;
  endfunction

  task automatic emit(input logic [31:0] w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  // ============================================================
  // program image
  // ============================================================
  task automatic load_program();
    for (int i = 0; i < PROG_WORDS; i++) prog[i] = 32'h0000_0013;
    prog_len = 0;
    emit(lui_word(5'd1, 20'h00001));
    // arithmetic at 0x1000
    emit(itype_word(12'd100, 5'd0, 3'd0, 5'd2, 7'h13));
    emit(itype_word(12'hFF9, 5'd0, 3'd0, 5'd3, 7'h13));
    emit(add_word(5'd4, 5'd2, 5'd3));
    emit(lui_word(5'd5, 20'hABCDE));
    emit(itype_word(12'hFFF, 5'd5, 3'd0, 5'd5, 7'h13));
    for (int i = 0; i < 4; i++) emit(stype_word(12'(4 * i), 5'(2 + i), 5'd1, 3'd2));
    // byte stores at 0x1100
    emit(itype_word(12'h100, 5'd1, 3'd0, 5'd6, 7'h13));
    emit(lui_word(5'd7, 20'h12345));
    emit(itype_word(12'h678, 5'd7, 3'd0, 5'd7, 7'h13));
    for (int i = 0; i < 4; i++) emit(stype_word(12'(i), 5'd7, 5'd6, 3'd0));
    emit(stype_word(12'd4, 5'd7, 5'd6, 3'd2));
    // loads, results stored at 0x1200
    emit(itype_word(12'h200, 5'd1, 3'd0, 5'd8, 7'h13));
    emit(itype_word(12'd4, 5'd6, 3'd2, 5'd9, 7'h03));
    emit(stype_word(12'd0, 5'd9, 5'd8, 3'd2));
    for (int i = 0; i < 4; i++) begin
      emit(itype_word(12'(4 + i), 5'd6, 3'd4, 5'd10, 7'h03));
      emit(stype_word(12'(4 + 4 * i), 5'd10, 5'd8, 3'd2));
    end
    emit(itype_word(12'd12, 5'd1, 3'd4, 5'd11, 7'h03));
    emit(stype_word(12'd20, 5'd11, 5'd8, 3'd2));
    emit(itype_word(12'd14, 5'd1, 3'd4, 5'd11, 7'h03));
    emit(stype_word(12'd24, 5'd11, 5'd8, 3'd2));
    // jalr to an odd target, skipping one store
    emit(itype_word(12'h300, 5'd1, 3'd0, 5'd12, 7'h13));
    emit(lui_word(5'd13, 20'h80000));
    emit(itype_word(12'((prog_len + 3) * 4 + 1), 5'd13, 3'd0, 5'd13, 7'h13));
    emit(itype_word(12'd0, 5'd13, 3'd0, 5'd14, 7'h67));
    emit(stype_word(12'd0, 5'd1, 5'd12, 3'd2));
    emit(stype_word(12'd4, 5'd14, 5'd12, 3'd2));
    // CSRs at 0x1400
    emit(itype_word(12'h400, 5'd1, 3'd0, 5'd15, 7'h13));
    emit(itype_word(`CSR_MVENDORID, 5'd0, 3'd2, 5'd2, 7'h73));
    emit(itype_word(`CSR_MARCHID, 5'd0, 3'd2, 5'd3, 7'h73));
    emit(itype_word(12'h100, 5'd0, 3'd0, 5'd4, 7'h13));
    emit(itype_word(`CSR_MCYCLEH, 5'd4, 3'd1, 5'd0, 7'h73));
    emit(itype_word(12'd3, 5'd0, 3'd0, 5'd4, 7'h13));
    emit(itype_word(`CSR_MCYCLEH, 5'd4, 3'd2, 5'd5, 7'h73));
    emit(itype_word(`CSR_MCYCLEH, 5'd0, 3'd2, 5'd6, 7'h73));
    emit(itype_word(`CSR_MCYCLE, 5'd0, 3'd2, 5'd7, 7'h73));
    emit(itype_word(`CSR_MCYCLE, 5'd0, 3'd2, 5'd9, 7'h73));
    for (int i = 0; i < 4; i++) emit(stype_word(12'(4 * i), 5'(2 + i), 5'd15, 3'd2));
    emit(stype_word(12'd16, 5'd6, 5'd15, 3'd2));
    emit(stype_word(12'd20, 5'd7, 5'd15, 3'd2));
    emit(stype_word(12'd24, 5'd9, 5'd15, 3'd2));
    // x0 at 0x1500
    emit(itype_word(12'h500, 5'd1, 3'd0, 5'd10, 7'h13));
    emit(itype_word(12'd55, 5'd0, 3'd0, 5'd0, 7'h13));
    emit(add_word(5'd0, 5'd2, 5'd2));
    emit(lui_word(5'd0, 20'h00012));
    emit(stype_word(12'd0, 5'd0, 5'd10, 3'd2));
    emit(itype_word(12'd5, 5'd0, 3'd0, 5'd11, 7'h13));
    emit(stype_word(12'd4, 5'd11, 5'd10, 3'd2));
    // park on a jalr to itself
    emit(lui_word(5'd13, 20'h80000));
    emit(itype_word(12'((prog_len + 1) * 4), 5'd13, 3'd0, 5'd13, 7'h13));
    emit(itype_word(12'd0, 5'd13, 3'd0, 5'd0, 7'h67));
  endtask

  // ============================================================
  // memory models, random latency of 1 to 4 cycles
  // ============================================================
  always @(posedge clk) begin
    #2;
    imem_resp.valid = 1'b0;
    if (rst) begin
      ipend = 1'b0;
    end else if (ipend) begin
      if (icnt > 1) begin
        icnt--;
      end else begin
        ioff = iaddr - `CORE_RESET_PC;
        imem_resp.data = (ioff < 32'(PROG_WORDS * 4)) ? prog[int'(ioff >> 2)] : 32'h13;
        imem_resp.valid = 1'b1;
        ipend = 1'b0;
      end
    end else if (imem_req.valid) begin
      ipend = 1'b1;
      iaddr = imem_req.addr;
      icnt = int'($urandom_range(4, 1));
    end
  end

  always @(posedge clk) begin
    #2;
    dmem_resp.valid = 1'b0;
    if (rst) begin
      dpend = 1'b0;
    end else if (dpend) begin
      if (dcnt > 1) begin
        dcnt--;
      end else begin
        dword = dmem.exists({dreq.addr[31:2], 2'b00}) ?
                dmem[{dreq.addr[31:2], 2'b00}] : fill_word({dreq.addr[31:2], 2'b00});
        if (dreq.wen) begin
          for (int b = 0; b < 4; b++) begin
            if (dreq.wmask[b]) dword[8*b +: 8] = dreq.wdata[8*b +: 8];
          end
          dmem[{dreq.addr[31:2], 2'b00}] = dword;
        end
        dmem_resp.rdata = dword;
        dmem_resp.valid = 1'b1;
        dpend = 1'b0;
      end
    end else if (dmem_req.valid) begin
      dpend = 1'b1;
      dreq = dmem_req;
      dcnt = int'($urandom_range(4, 1));
    end
  end

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    int cycles;
    void'($urandom(32'h8d031fe9));
    rst = 1'b1;
    imem_resp = '0;
    dmem_resp = '0;
    load_program();
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    cycles = 0;
    while (!mon_done && cycles < RUN_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (!mon_done) begin
      $display("run did not finish within %0d cycles", RUN_TIMEOUT);
      $display("TEST FAILED");
    end else begin
      $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
               error_count);
      if (error_count == 0 && tests_failed == 0) begin
        $display("TEST PASSED");
      end else begin
        $display("TEST FAILED");
      end
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+include
src/core_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/reg_file.sv
src/execute_stage.sv
src/csr_file.sv
src/mem_stage.sv
src/writeback_stage.sv
src/core_top.sv
bench/check_monitor.sv
bench/tb_top.sv

//--- run.sh
#!/bin/sh
# build and run with Verilator, then scan the log for the fail message
rm -f sim.log
verilator --binary --timing -f build.f --top-module tb_top -o sim_tb > sim.log 2>&1 && \
  ./obj_dir/sim_tb >> sim.log 2>&1 || { cat sim.log; echo "build or run error"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
